/* common/core_params.svh */
/*
 * Core parameters shared by the RTL and the testbench
 */

`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Data and address width
`define CORE_XLEN 64

// Address of the first instruction fetched after reset
`define CORE_RESET_PC 64'h0000_0000_0000_1000

// Architectural integer registers, x0 included
`define CORE_NREGS 32

`endif

/* common/core_pkg.sv */
/*
 * Core types: instruction word views, cache request and response
 * structs, memory and ALU operation encodings, major opcodes
 */

`include "core_params.svh"

package core_pkg;

    // Register-register layout, also the source of I and B immediates
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // Store layout
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef union packed {
        r_fmt_t r;
        s_fmt_t s;
    } instr_u;

    typedef enum logic {
        MEM_LOAD  = 1'b0,
        MEM_STORE = 1'b1
    } mem_op_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_EQ  = 3'd5
    } alu_op_e;

    typedef struct packed {
        logic [`CORE_XLEN-1:0] pc;
    } icache_req_t;

    typedef struct packed {
        logic [`CORE_XLEN-1:0] pc;
        instr_u                instr;
    } icache_resp_t;

    typedef struct packed {
        logic [`CORE_XLEN-1:0] address;
        logic [`CORE_XLEN-1:0] value;
        mem_op_e               op;
    } dcache_req_t;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

endpackage

/* execute/execute_stage.sv */
/*
 * Execute stage: decodes the issued instruction, computes ALU and
 * branch results, runs the data cache handshake and retires
 */

`include "core_params.svh"

module execute_stage (
    input  logic                   clk_i,
    input  logic                   rst,
    input  logic                   issue_valid,
    input  core_pkg::icache_resp_t issue,
    output logic [4:0]             rs1_addr,
    output logic [4:0]             rs2_addr,
    input  logic [`CORE_XLEN-1:0]  rs1_data,
    input  logic [`CORE_XLEN-1:0]  rs2_data,
    output logic                   rd_we,
    output logic [4:0]             rd_addr,
    output logic [`CORE_XLEN-1:0]  rd_data,
    output logic                   dcache_req_valid,
    output core_pkg::dcache_req_t  dcache_req,
    input  logic                   dcache_req_ready,
    input  logic                   dcache_resp_valid,
    input  logic [`CORE_XLEN-1:0]  dcache_resp_value,
    output logic                   retire,
    output logic [`CORE_XLEN-1:0]  next_pc,
    output logic [`CORE_XLEN-1:0]  dbg_pc
);

    import core_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_EXEC,
        S_MEM_REQ,
        S_MEM_WAIT
    } state_e;

    state_e                state_q, state_d;
    instr_u                instr_q;
    logic [`CORE_XLEN-1:0] pc_q;
    logic [`CORE_XLEN-1:0] dbg_pc_q;

    logic                  is_op, is_op_imm, is_load, is_store, is_branch;
    logic                  is_mem, writes_rd, taken;
    alu_op_e               alu_op;
    logic [`CORE_XLEN-1:0] imm_i, imm_s, imm_b;
    logic [`CORE_XLEN-1:0] operand_b, alu_result;

    // Instruction and its pc are held until retire
    always_ff @(posedge clk_i) begin
        if (issue_valid) begin
            instr_q <= issue.instr;
            pc_q    <= issue.pc;
        end
    end

    // Only doubleword loads and stores and ADDI are recognised
    assign is_op     = instr_q.r.opcode == OPC_OP;
    assign is_op_imm = instr_q.r.opcode == OPC_OP_IMM && instr_q.r.funct3 == 3'b000;
    assign is_load   = instr_q.r.opcode == OPC_LOAD && instr_q.r.funct3 == 3'b011;
    assign is_store  = instr_q.s.opcode == OPC_STORE && instr_q.s.funct3 == 3'b011;
    assign is_branch = instr_q.r.opcode == OPC_BRANCH;
    assign is_mem    = is_load || is_store;
    assign writes_rd = is_op || is_op_imm || is_load;

    assign imm_i = {{52{instr_q.r.funct7[6]}}, instr_q.r.funct7, instr_q.r.rs2};
    assign imm_s = {{52{instr_q.s.imm_hi[6]}}, instr_q.s.imm_hi, instr_q.s.imm_lo};
    // B immediate is scattered over the funct7 and rd fields
    assign imm_b = {{51{instr_q.r.funct7[6]}}, instr_q.r.funct7[6], instr_q.r.rd[0],
                    instr_q.r.funct7[5:0], instr_q.r.rd[4:1], 1'b0};

    always_comb begin
        alu_op = ALU_ADD;
        if (is_branch) begin
            alu_op = ALU_EQ;
        end else if (is_op) begin
            case (instr_q.r.funct3)
                3'b000:  alu_op = instr_q.r.funct7[5] ? ALU_SUB : ALU_ADD;
                3'b100:  alu_op = ALU_XOR;
                3'b110:  alu_op = ALU_OR;
                3'b111:  alu_op = ALU_AND;
                default: alu_op = ALU_ADD;
            endcase
        end
    end

    // Loads and stores compute their address through the adder
    assign operand_b = (is_op || is_branch) ? rs2_data :
                       is_store ? imm_s : imm_i;

    always_comb begin
        case (alu_op)
            ALU_SUB: alu_result = rs1_data - operand_b;
            ALU_AND: alu_result = rs1_data & operand_b;
            ALU_OR:  alu_result = rs1_data | operand_b;
            ALU_XOR: alu_result = rs1_data ^ operand_b;
            ALU_EQ:  alu_result = {{(`CORE_XLEN-1){1'b0}}, rs1_data == operand_b};
            default: alu_result = rs1_data + operand_b;
        endcase
    end

    // BEQ and BNE only, other funct3 values fall through
    assign taken = is_branch &&
                   ((instr_q.r.funct3 == 3'b000 && alu_result[0]) ||
                    (instr_q.r.funct3 == 3'b001 && !alu_result[0]));

    always_comb begin
        state_d          = state_q;
        retire           = 1'b0;
        dcache_req_valid = 1'b0;
        case (state_q)
            S_IDLE: begin
                if (issue_valid) begin
                    state_d = S_EXEC;
                end
            end
            S_EXEC, S_MEM_REQ: begin
                if (!is_mem) begin
                    // ALU, branch and unknown opcodes finish here
                    retire  = 1'b1;
                    state_d = S_IDLE;
                end else begin
                    dcache_req_valid = 1'b1;
                    if (!dcache_req_ready) begin
                        state_d = S_MEM_REQ;
                    end else if (is_store) begin
                        retire  = 1'b1;
                        state_d = S_IDLE;
                    end else begin
                        state_d = S_MEM_WAIT;
                    end
                end
            end
            S_MEM_WAIT: begin
                if (dcache_resp_valid) begin
                    retire  = 1'b1;
                    state_d = S_IDLE;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst) begin
            state_q  <= S_IDLE;
            dbg_pc_q <= `CORE_RESET_PC;
        end else begin
            state_q <= state_d;
            if (retire) begin
                dbg_pc_q <= pc_q;
            end
        end
    end

    assign rs1_addr = instr_q.r.rs1;
    assign rs2_addr = instr_q.r.rs2;

    assign rd_we   = retire && writes_rd;
    assign rd_addr = instr_q.r.rd;
    assign rd_data = is_load ? dcache_resp_value : alu_result;

    assign dcache_req.address = alu_result;
    assign dcache_req.value   = rs2_data;
    assign dcache_req.op      = is_store ? MEM_STORE : MEM_LOAD;

    assign next_pc = taken ? pc_q + imm_b : pc_q + `CORE_XLEN'd4;
    assign dbg_pc  = dbg_pc_q;

endmodule

/* fetch/fetch_unit.sv */
/*
 * Fetch unit: owns the PC, sends one instruction request at a time
 * and passes each response on to execute as a single issue strobe
 */

`include "core_params.svh"

module fetch_unit (
    input  logic                   clk_i,
    input  logic                   rst,
    output logic                   icache_req_valid,
    output core_pkg::icache_req_t  icache_req,
    input  logic                   icache_resp_valid,
    input  core_pkg::icache_resp_t icache_resp,
    input  logic                   retire,
    input  logic [`CORE_XLEN-1:0]  next_pc,
    output logic                   issue_valid,
    output core_pkg::icache_resp_t issue
);

    import core_pkg::*;

    logic [`CORE_XLEN-1:0] pc_q;
    logic                  boot_q;
    logic                  req_valid_q;
    logic                  outstanding_q;
    logic                  issue_valid_q;
    icache_resp_t          issue_q;

    // First request goes out from the first edge that sees rst low,
    // later ones from the edge that retires the previous instruction
    always_ff @(posedge clk_i) begin
        if (rst) begin
            pc_q          <= `CORE_RESET_PC;
            boot_q        <= 1'b1;
            req_valid_q   <= 1'b0;
            outstanding_q <= 1'b0;
            issue_valid_q <= 1'b0;
        end else begin
            boot_q      <= 1'b0;
            req_valid_q <= boot_q || retire;
            if (retire) begin
                pc_q <= next_pc;
            end
            if (req_valid_q) begin
                outstanding_q <= 1'b1;
            end else if (icache_resp_valid) begin
                outstanding_q <= 1'b0;
            end
            // Stray responses are dropped
            issue_valid_q <= icache_resp_valid && outstanding_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (icache_resp_valid && outstanding_q) begin
            issue_q <= icache_resp;
        end
    end

    assign icache_req_valid = req_valid_q;
    assign icache_req.pc    = pc_q;
    assign issue_valid      = issue_valid_q;
    assign issue            = issue_q;

endmodule

/* logic/core_pipeline.sv */
/*
 * Core: fetch unit, execute stage and register file joined together
 */

`include "core_params.svh"

module core_pipeline (
    input  logic                   clk_i,
    input  logic                   rst,
    output logic                   icache_req_valid,
    output core_pkg::icache_req_t  icache_req,
    input  logic                   icache_resp_valid,
    input  core_pkg::icache_resp_t icache_resp,
    output logic                   dcache_req_valid,
    output core_pkg::dcache_req_t  dcache_req,
    input  logic                   dcache_req_ready,
    input  logic                   dcache_resp_valid,
    input  logic [`CORE_XLEN-1:0]  dcache_resp_value,
    output logic [`CORE_XLEN-1:0]  dbg_pc
);

    import core_pkg::*;

    logic                  issue_valid;
    icache_resp_t          issue;
    logic                  retire;
    logic [`CORE_XLEN-1:0] next_pc;

    logic [4:0]            rs1_addr, rs2_addr, rd_addr;
    logic [`CORE_XLEN-1:0] rs1_data, rs2_data, rd_data;
    logic                  rd_we;

    fetch_unit fetch (
        .clk_i             (clk_i),
        .rst               (rst),
        .icache_req_valid  (icache_req_valid),
        .icache_req        (icache_req),
        .icache_resp_valid (icache_resp_valid),
        .icache_resp       (icache_resp),
        .retire            (retire),
        .next_pc           (next_pc),
        .issue_valid       (issue_valid),
        .issue             (issue)
    );

    execute_stage execute (
        .clk_i             (clk_i),
        .rst               (rst),
        .issue_valid       (issue_valid),
        .issue             (issue),
        .rs1_addr          (rs1_addr),
        .rs2_addr          (rs2_addr),
        .rs1_data          (rs1_data),
        .rs2_data          (rs2_data),
        .rd_we             (rd_we),
        .rd_addr           (rd_addr),
        .rd_data           (rd_data),
        .dcache_req_valid  (dcache_req_valid),
        .dcache_req        (dcache_req),
        .dcache_req_ready  (dcache_req_ready),
        .dcache_resp_valid (dcache_resp_valid),
        .dcache_resp_value (dcache_resp_value),
        .retire            (retire),
        .next_pc           (next_pc),
        .dbg_pc            (dbg_pc)
    );

    reg_file regs (
        .clk_i    (clk_i),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (rd_we),
        .wr_addr  (rd_addr),
        .wr_data  (rd_data)
    );

endmodule

/* logic/pipeline_wrapper.sv */
/*
 * Top level: presents the core's cache request and response structs
 * as flat ports so a Verilator harness can drive them directly
 */

`include "core_params.svh"

module pipeline_wrapper (
    input  logic                  clk_i,
    input  logic                  rst,

    // Instruction cache port
    output logic                  icache_req_valid,
    output logic [`CORE_XLEN-1:0] icache_req_pc,
    input  logic                  icache_resp_valid,
    input  logic [`CORE_XLEN-1:0] icache_resp_pc,
    input  logic [31:0]           icache_resp_instr,

    // Data cache port
    output logic                  dcache_req_valid,
    output logic [`CORE_XLEN-1:0] dcache_req_address,
    output logic [`CORE_XLEN-1:0] dcache_req_value,
    output core_pkg::mem_op_e     dcache_req_op,
    input  logic                  dcache_req_ready,
    input  logic                  dcache_resp_valid,
    input  logic [`CORE_XLEN-1:0] dcache_resp_value,

    // Pc of the last retired instruction
    output logic [`CORE_XLEN-1:0] dbg_pc
);

    import core_pkg::*;

    icache_req_t  icache_req;
    icache_resp_t icache_resp;
    dcache_req_t  dcache_req;

    core_pipeline pipeline (
        .clk_i             (clk_i),
        .rst               (rst),
        .icache_req_valid  (icache_req_valid),
        .icache_req        (icache_req),
        .icache_resp_valid (icache_resp_valid),
        .icache_resp       (icache_resp),
        .dcache_req_valid  (dcache_req_valid),
        .dcache_req        (dcache_req),
        .dcache_req_ready  (dcache_req_ready),
        .dcache_resp_valid (dcache_resp_valid),
        .dcache_resp_value (dcache_resp_value),
        .dbg_pc            (dbg_pc)
    );

    // Instruction side
    assign icache_req_pc     = icache_req.pc;
    assign icache_resp.pc    = icache_resp_pc;
    assign icache_resp.instr = icache_resp_instr;

    // Data side, the response value goes straight through to the core
    assign dcache_req_address = dcache_req.address;
    assign dcache_req_value   = dcache_req.value;
    assign dcache_req_op      = dcache_req.op;

endmodule

/* logic/reg_file.sv */
/*
 * Integer register file, two asynchronous read ports and one
 * synchronous write port, x0 reads as zero
 */

`include "core_params.svh"

module reg_file (
    input  logic                              clk_i,
    input  logic [$clog2(`CORE_NREGS)-1:0]    rs1_addr,
    input  logic [$clog2(`CORE_NREGS)-1:0]    rs2_addr,
    output logic [`CORE_XLEN-1:0]             rs1_data,
    output logic [`CORE_XLEN-1:0]             rs2_data,
    input  logic                              we,
    input  logic [$clog2(`CORE_NREGS)-1:0]    wr_addr,
    input  logic [`CORE_XLEN-1:0]             wr_data
);

    logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];

    // Writes to x0 land in the array but are never seen
    always_ff @(posedge clk_i) begin
        if (we) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the core and testbench with Verilator, run, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module pipeline_tb -f src.f -j 0 || exit 1
out=$(./obj_dir/Vpipeline_tb +verilator+error+limit+1000)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Simulation PASSED" && exit 0 || exit 1

/* src.f */
+incdir+common
common/core_pkg.sv
fetch/fetch_unit.sv
execute/execute_stage.sv
logic/reg_file.sv
logic/core_pipeline.sv
logic/pipeline_wrapper.sv
verification/pipeline_assert.sv
verification/pipeline_tb.sv

/* verification/pipeline_assert.sv */
/*
 * Protocol assertions on the cache ports of pipeline_wrapper
 */

`include "core_params.svh"

module pipeline_assert (
    input logic                  clk_i,
    input logic                  rst,
    input logic                  icache_req_valid,
    input logic                  dcache_req_valid,
    input logic                  dcache_req_ready,
    input logic [`CORE_XLEN-1:0] dcache_req_address,
    input logic [`CORE_XLEN-1:0] dcache_req_value,
    input core_pkg::mem_op_e     dcache_req_op
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;

    // Instruction requests are one-cycle strobes
    a_ireq_pulse: assert property (
        @(posedge clk_i) disable iff (rst) icache_req_valid |=> !icache_req_valid
    ) else begin
        fail_count++;
        $error("Instruction request held high for two cycles");
    end

    // Stalled data request keeps every field
    a_dreq_stable: assert property (
        @(posedge clk_i) disable iff (rst)
        (dcache_req_valid && !dcache_req_ready) |=>
        (dcache_req_valid && $stable(dcache_req_address) &&
         $stable(dcache_req_value) && $stable(dcache_req_op))
    ) else begin
        fail_count++;
        $error("Data request changed or dropped while stalled");
    end

    // First reset edge still sees power-up state
    a_reset_idle: assert property (
        @(posedge clk_i) (rst && $past(rst)) |-> (!icache_req_valid && !dcache_req_valid)
    ) else begin
        fail_count++;
        $error("Request valid high during reset");
    end

endmodule

bind pipeline_wrapper pipeline_assert checks (
    .clk_i              (clk_i),
    .rst                (rst),
    .icache_req_valid   (icache_req_valid),
    .dcache_req_valid   (dcache_req_valid),
    .dcache_req_ready   (dcache_req_ready),
    .dcache_req_address (dcache_req_address),
    .dcache_req_value   (dcache_req_value),
    .dcache_req_op      (dcache_req_op)
);

/* verification/pipeline_tb.sv */
/*
 * Testbench for pipeline_wrapper with random instructions and memory
 * responses checked against an ISA model of the supported subset
 */

`include "core_params.svh"

module pipeline_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import core_pkg::*;

    localparam int NUM_INSTR  = 400;
    localparam int MAX_LAT    = 32;
    localparam int CLK_PERIOD = 40;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  icache_req_valid, icache_resp_valid;
    logic [`CORE_XLEN-1:0] icache_req_pc, icache_resp_pc;
    logic [31:0]           icache_resp_instr;
    logic                  dcache_req_valid, dcache_req_ready, dcache_resp_valid;
    logic [`CORE_XLEN-1:0] dcache_req_address, dcache_req_value, dcache_resp_value;
    mem_op_e               dcache_req_op;
    logic [`CORE_XLEN-1:0] dbg_pc;

    // Reference model and environment state
    logic [15:0] lfsr = 16'd47;
    logic [63:0] model_regs [8];
    logic [63:0] ref_mem [logic [63:0]];
    logic [63:0] dut_mem [logic [63:0]];
    dcache_req_t exp_q [$];
    logic [63:0] retired_q [$];
    logic [63:0] exp_pc   = `CORE_RESET_PC;
    logic [63:0] last_dbg = `CORE_RESET_PC;
    logic [63:0] ic_pc, ld_value;
    logic [31:0] ic_word;
    logic        ic_busy = 1'b0;
    logic        ld_busy = 1'b0;
    logic        done = 1'b0;
    int          n_instr = 0;
    int          n_mem_exp = 0;
    int          n_xfer = 0;
    int          n_checks = 0;
    int          n_errors = 0;
    int          ic_wait, ld_wait;

    always #(CLK_PERIOD / 2) clk = ~clk;

    pipeline_wrapper UUT (
        .clk_i              (clk),
        .rst                (rst),
        .icache_req_valid   (icache_req_valid),
        .icache_req_pc      (icache_req_pc),
        .icache_resp_valid  (icache_resp_valid),
        .icache_resp_pc     (icache_resp_pc),
        .icache_resp_instr  (icache_resp_instr),
        .dcache_req_valid   (dcache_req_valid),
        .dcache_req_address (dcache_req_address),
        .dcache_req_value   (dcache_req_value),
        .dcache_req_op      (dcache_req_op),
        .dcache_req_ready   (dcache_req_ready),
        .dcache_resp_valid  (dcache_resp_valid),
        .dcache_resp_value  (dcache_resp_value),
        .dbg_pc             (dbg_pc)
    );

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic logic [63:0] fill_word(input logic [63:0] addr);
        return addr ^ 64'h5A5A_C3C3_0F0F_9696;
    endfunction

    task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // Builds one random instruction and executes it on the model
    task automatic make_instr(input int seq, input logic [63:0] pc, output logic [31:0] word);
        instr_u      ins;
        alu_op_e     op;
        dcache_req_t req;
        logic [2:0]  kind, rd, rs1, rs2;
        logic [11:0] imm12;
        logic [4:0]  off;
        logic [12:0] boff;
        logic [63:0] a, b, res, addr, diff;
        logic        wr;
        kind  = 3'(rand_bits(3));
        rd    = 3'(rand_bits(3));
        rs1   = 3'(rand_bits(3));
        rs2   = 3'(rand_bits(3));
        imm12 = 12'(rand_bits(12));
        // Registers power up unknown, so the first fetches set x1 to x7
        if (seq < 7) begin
            kind = 3'd3;
            rd   = 3'(seq + 1);
            rs1  = 3'd0;
        end
        ins       = '0;
        ins.r.rd  = {2'b00, rd};
        ins.r.rs2 = {2'b00, rs2};
        a         = model_regs[rs1];
        b         = model_regs[rs2];
        res       = a + {{52{imm12[11]}}, imm12};
        wr        = 1'b1;
        exp_pc    = pc + 64'd4;
        retired_q.push_back(pc);
        case (kind)
            3'd3: begin
                ins.r.opcode = OPC_OP_IMM;
                {ins.r.funct7, ins.r.rs2} = imm12;
            end
            3'd4, 3'd5: begin
                // Doubleword in the window is reached from rs1 when the offset fits
                addr = {53'd0, 8'(rand_bits(8)), 3'd0};
                diff = addr - a;
                if ($signed(diff) >= -64'sd2048 && $signed(diff) <= 64'sd2047) begin
                    imm12 = diff[11:0];
                end else begin
                    rs1   = 3'd0;
                    imm12 = addr[11:0];
                end
                req.address = addr;
                req.value   = b;
                n_mem_exp++;
                if (kind == 3'd4) begin
                    ins.r.opcode = OPC_LOAD;
                    ins.r.funct3 = 3'b011;
                    {ins.r.funct7, ins.r.rs2} = imm12;
                    req.op = MEM_LOAD;
                    res    = ref_mem.exists(addr) ? ref_mem[addr] : fill_word(addr);
                end else begin
                    ins.s.opcode = OPC_STORE;
                    ins.s.funct3 = 3'b011;
                    {ins.s.imm_hi, ins.s.imm_lo} = imm12;
                    req.op        = MEM_STORE;
                    ref_mem[addr] = b;
                    wr            = 1'b0;
                end
                exp_q.push_back(req);
            end
            3'd6, 3'd7: begin
                // Nonzero offset so consecutive retired pcs differ
                off = 5'(rand_bits(5));
                if (off == 5'd0) begin
                    off = 5'd1;
                end
                boff         = {{6{off[4]}}, off, 2'b00};
                ins.r.opcode = OPC_BRANCH;
                ins.r.funct3 = {2'b00, kind[0]};
                ins.r.funct7 = {boff[12], boff[10:5]};
                ins.r.rd     = {boff[4:1], boff[11]};
                if (kind[0] ? (a != b) : (a == b)) begin
                    exp_pc = pc + {{51{boff[12]}}, boff};
                end
                wr = 1'b0;
            end
            default: begin
                op = alu_op_e'(3'(rand_bits(3)) % 3'd5);
                ins.r.opcode = OPC_OP;
                case (op)
                    ALU_SUB: begin
                        ins.r.funct7 = 7'b0100000;
                        res = a - b;
                    end
                    ALU_AND: begin
                        ins.r.funct3 = 3'b111;
                        res = a & b;
                    end
                    ALU_OR: begin
                        ins.r.funct3 = 3'b110;
                        res = a | b;
                    end
                    ALU_XOR: begin
                        ins.r.funct3 = 3'b100;
                        res = a ^ b;
                    end
                    default: res = a + b;
                endcase
            end
        endcase
        ins.r.rs1 = {2'b00, rs1};
        if (wr && rd != 3'd0) begin
            model_regs[rd] = res;
        end
        word = ins;
    endtask

    // Instruction memory, data memory and retire monitor
    always @(posedge clk) begin : environment
        logic [31:0] word;
        dcache_req_t want;
        icache_resp_valid <= 1'b0;
        dcache_resp_valid <= 1'b0;
        if (!rst) begin
            dcache_req_ready <= (rand_bits(2) != 32'd0);
            if (dbg_pc !== last_dbg) begin
                // A retire that repeats the previous pc leaves dbg_pc unchanged
                while (retired_q.size() > 0 && retired_q[0] == last_dbg) begin
                    void'(retired_q.pop_front());
                end
                if (retired_q.size() == 0) begin
                    n_errors++;
                    $display("dbg_pc changed to %h with no instruction left to retire", dbg_pc);
                end else begin
                    compare("retired_pc", retired_q.pop_front(), dbg_pc);
                end
                last_dbg = dbg_pc;
            end
            if (icache_req_valid) begin
                compare("fetch_pc", exp_pc, icache_req_pc);
                if (n_instr == NUM_INSTR) begin
                    done = 1'b1;
                end else begin
                    make_instr(n_instr, exp_pc, word);
                    ic_pc   = icache_req_pc;
                    ic_word = word;
                    ic_wait = int'(rand_bits(2));
                    ic_busy = 1'b1;
                    n_instr++;
                end
            end
            if (ic_busy) begin
                if (ic_wait == 0) begin
                    icache_resp_valid <= 1'b1;
                    icache_resp_pc    <= ic_pc;
                    icache_resp_instr <= ic_word;
                    ic_busy = 1'b0;
                end else begin
                    ic_wait--;
                end
            end
            if (dcache_req_valid && dcache_req_ready) begin
                n_xfer++;
                if (exp_q.size() == 0) begin
                    n_errors++;
                    $display("Data request seen with no memory instruction outstanding");
                end else begin
                    want = exp_q.pop_front();
                    compare("data_address", want.address, dcache_req_address);
                    compare("data_op", 64'(want.op), 64'(dcache_req_op));
                    if (want.op == MEM_STORE) begin
                        compare("store_value", want.value, dcache_req_value);
                    end
                end
                if (dcache_req_op == MEM_STORE) begin
                    dut_mem[dcache_req_address] = dcache_req_value;
                end else begin
                    ld_value = dut_mem.exists(dcache_req_address) ?
                               dut_mem[dcache_req_address] : fill_word(dcache_req_address);
                    ld_wait  = int'(rand_bits(2));
                    ld_busy  = 1'b1;
                end
            end
            if (ld_busy) begin
                if (ld_wait == 0) begin
                    dcache_resp_valid <= 1'b1;
                    dcache_resp_value <= ld_value;
                    ld_busy = 1'b0;
                end else begin
                    ld_wait--;
                end
            end
        end
    end

    initial begin
        rst               = 1'b1;
        icache_resp_valid = 1'b0;
        icache_resp_pc    = '0;
        icache_resp_instr = '0;
        dcache_req_ready  = 1'b0;
        dcache_resp_valid = 1'b0;
        dcache_resp_value = '0;
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = '0;
        end
        // dbg_pc is still unknown before the first reset edge
        @(posedge clk);
        repeat (7) begin
            @(posedge clk);
            compare("reset_dbg_pc", `CORE_RESET_PC, dbg_pc);
        end
        rst <= 1'b0;
        wait (done);
        compare("data_transfers", 64'(n_mem_exp), 64'(n_xfer));
        compare("pending_data_requests", 64'd0, 64'(exp_q.size()));
        compare("pending_retires", 64'd0, 64'(retired_q.size()));
        n_errors += int'(UUT.checks.fail_count);
        $display("Finished %0d instructions: %0d checks, %0d errors",
                 n_instr, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog allows every instruction the worst random latency
    initial begin
        #(NUM_INSTR * MAX_LAT * CLK_PERIOD);
        $display("Timeout: the core stopped making progress before all instructions retired");
        $display("Simulation FAILED");
        $finish;
    end

endmodule
